/* common/rv_pkg.sv */
package rv_pkg;

    typedef logic [31:0] xlen_t;     // data, address and instruction word
    typedef logic [4:0]  reg_idx_t;  // architectural register index

    // major opcodes, instr[6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    // funct7 patterns shared by op and the shift immediates
    localparam logic [6:0] F7_BASE = 7'h00;
    localparam logic [6:0] F7_ALT  = 7'h20;  // sub, sra, srai

    typedef enum logic [5:0] {
        INSTR_ADD,
        INSTR_SUB,
        INSTR_XOR,
        INSTR_OR,
        INSTR_AND,
        INSTR_SLL,
        INSTR_SRL,
        INSTR_SRA,
        INSTR_SLT,
        INSTR_SLTU,
        INSTR_ADDI,
        INSTR_XORI,
        INSTR_ORI,
        INSTR_ANDI,
        INSTR_SLLI,
        INSTR_SRLI,
        INSTR_SRAI,
        INSTR_SLTI,
        INSTR_SLTIU,
        INSTR_LB,
        INSTR_LH,
        INSTR_LW,
        INSTR_LBU,
        INSTR_LHU,
        INSTR_SB,
        INSTR_SH,
        INSTR_SW,
        INSTR_BEQ,
        INSTR_BNE,
        INSTR_BLT,
        INSTR_BGE,
        INSTR_BLTU,
        INSTR_BGEU,
        INSTR_JAL,
        INSTR_JALR,
        INSTR_LUI,
        INSTR_AUIPC,
        INSTR_INVALID
    } instr_id_t;

    // decoder output, indices the format does not use are zero
    typedef struct packed {
        instr_id_t id;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        reg_idx_t  rd;
        xlen_t     imm;
        logic      rs1_valid;
        logic      rs2_valid;
    } decoded_t;

    // one record per retired instruction
    typedef struct packed {
        xlen_t    pc;
        xlen_t    instr;
        reg_idx_t rd;
        xlen_t    wdata;
        logic     wen;
        xlen_t    next_pc;
        logic     illegal;
    } retire_t;

endpackage

/* decode/rv_decoder.sv */
module rv_decoder import rv_pkg::*; (
    input  xlen_t    instr,
    output decoded_t dec
);

    logic      is_r, is_i, is_s, is_b, is_u, is_j;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t     imm;
    instr_id_t id;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign is_r = (opcode == OPC_OP);
    assign is_i = (opcode == OPC_OP_IMM) || (opcode == OPC_LOAD) || (opcode == OPC_JALR);
    assign is_s = (opcode == OPC_STORE);
    assign is_b = (opcode == OPC_BRANCH);
    assign is_u = (opcode == OPC_LUI) || (opcode == OPC_AUIPC);
    assign is_j = (opcode == OPC_JAL);

    // sign bit always sits in instr[31]
    assign imm =
        is_i ? {{21{instr[31]}}, instr[30:20]} :
        is_s ? {{21{instr[31]}}, instr[30:25], instr[11:7]} :
        is_b ? {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0} :
        is_u ? {instr[31:12], 12'b0} :
        is_j ? {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0} :
        '0;

    always_comb begin
        case (opcode)
            OPC_OP: begin
                case ({funct7, funct3})
                    {F7_BASE, 3'h0}: id = INSTR_ADD;
                    {F7_ALT,  3'h0}: id = INSTR_SUB;
                    {F7_BASE, 3'h4}: id = INSTR_XOR;
                    {F7_BASE, 3'h6}: id = INSTR_OR;
                    {F7_BASE, 3'h7}: id = INSTR_AND;
                    {F7_BASE, 3'h1}: id = INSTR_SLL;
                    {F7_BASE, 3'h5}: id = INSTR_SRL;
                    {F7_ALT,  3'h5}: id = INSTR_SRA;
                    {F7_BASE, 3'h2}: id = INSTR_SLT;
                    {F7_BASE, 3'h3}: id = INSTR_SLTU;
                    default:         id = INSTR_INVALID;
                endcase
            end
            OPC_OP_IMM: begin
                case (funct3)
                    3'h0: id = INSTR_ADDI;
                    3'h4: id = INSTR_XORI;
                    3'h6: id = INSTR_ORI;
                    3'h7: id = INSTR_ANDI;
                    3'h1: id = (funct7 == F7_BASE) ? INSTR_SLLI : INSTR_INVALID;
                    3'h5: begin  // shift kind sits in the upper imm bits
                        if (funct7 == F7_BASE)
                            id = INSTR_SRLI;
                        else if (funct7 == F7_ALT)
                            id = INSTR_SRAI;
                        else
                            id = INSTR_INVALID;
                    end
                    3'h2: id = INSTR_SLTI;
                    default: id = INSTR_SLTIU;  // funct3 3
                endcase
            end
            OPC_LOAD: begin
                case (funct3)
                    3'h0: id = INSTR_LB;
                    3'h1: id = INSTR_LH;
                    3'h2: id = INSTR_LW;
                    3'h4: id = INSTR_LBU;
                    3'h5: id = INSTR_LHU;
                    default: id = INSTR_INVALID;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    3'h0: id = INSTR_SB;
                    3'h1: id = INSTR_SH;
                    3'h2: id = INSTR_SW;
                    default: id = INSTR_INVALID;
                endcase
            end
            OPC_BRANCH: begin
                case (funct3)
                    3'h0: id = INSTR_BEQ;
                    3'h1: id = INSTR_BNE;
                    3'h4: id = INSTR_BLT;
                    3'h5: id = INSTR_BGE;
                    3'h6: id = INSTR_BLTU;
                    3'h7: id = INSTR_BGEU;
                    default: id = INSTR_INVALID;
                endcase
            end
            OPC_JAL:   id = INSTR_JAL;
            OPC_JALR:  id = (funct3 == 3'h0) ? INSTR_JALR : INSTR_INVALID;
            OPC_LUI:   id = INSTR_LUI;
            OPC_AUIPC: id = INSTR_AUIPC;
            default:   id = INSTR_INVALID;
        endcase
    end

    assign dec = '{
        id:        id,
        rs1:       (is_r || is_i || is_s || is_b) ? instr[19:15] : 5'd0,
        rs2:       (is_r || is_s || is_b) ? instr[24:20] : 5'd0,
        rd:        (is_r || is_i || is_u || is_j) ? instr[11:7] : 5'd0,
        imm:       imm,
        rs1_valid: is_r || is_i || is_s || is_b,
        rs2_valid: is_r || is_s || is_b
    };

endmodule

/* source/rv_regfile.sv */
module rv_regfile import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wen,
    input  reg_idx_t waddr,
    input  xlen_t    wdata,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    output xlen_t    rdata1,
    output xlen_t    rdata2
);

    xlen_t regs [1:31];  // x0 has no storage

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // write lands at the edge, so the next cycle reads it directly
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

/* source/rv_alu.sv */
module rv_alu import rv_pkg::*; (
    input  decoded_t dec,
    input  xlen_t    pc,
    input  xlen_t    rs1_data,
    input  xlen_t    rs2_data,
    output xlen_t    wdata,
    output logic     wen,
    output xlen_t    next_pc,
    output logic     illegal
);

    xlen_t      op_b;
    xlen_t      result;
    xlen_t      pc_plus4;
    logic       taken;
    logic       is_mem;
    logic [4:0] shamt;

    assign op_b     = dec.rs2_valid ? rs2_data : dec.imm;
    assign shamt    = op_b[4:0];
    assign pc_plus4 = pc + 32'd4;

    assign is_mem = dec.id inside {INSTR_LB, INSTR_LH, INSTR_LW, INSTR_LBU, INSTR_LHU,
                                   INSTR_SB, INSTR_SH, INSTR_SW};

    always_comb begin
        case (dec.id)
            INSTR_ADD, INSTR_ADDI:   result = rs1_data + op_b;
            INSTR_SUB:               result = rs1_data - op_b;
            INSTR_XOR, INSTR_XORI:   result = rs1_data ^ op_b;
            INSTR_OR, INSTR_ORI:     result = rs1_data | op_b;
            INSTR_AND, INSTR_ANDI:   result = rs1_data & op_b;
            INSTR_SLL, INSTR_SLLI:   result = rs1_data << shamt;
            INSTR_SRL, INSTR_SRLI:   result = rs1_data >> shamt;
            INSTR_SRA, INSTR_SRAI:   result = xlen_t'($signed(rs1_data) >>> shamt);
            INSTR_SLT, INSTR_SLTI:   result = {31'd0, $signed(rs1_data) < $signed(op_b)};
            INSTR_SLTU, INSTR_SLTIU: result = {31'd0, rs1_data < op_b};
            INSTR_JAL, INSTR_JALR:   result = pc_plus4;  // link
            INSTR_LUI:               result = dec.imm;
            INSTR_AUIPC:             result = pc + dec.imm;
            default:                 result = '0;
        endcase
    end

    always_comb begin
        case (dec.id)
            INSTR_BEQ:  taken = (rs1_data == rs2_data);
            INSTR_BNE:  taken = (rs1_data != rs2_data);
            INSTR_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
            INSTR_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            INSTR_BLTU: taken = (rs1_data < rs2_data);
            INSTR_BGEU: taken = (rs1_data >= rs2_data);
            INSTR_JAL:  taken = 1'b1;
            default:    taken = 1'b0;
        endcase
    end

    assign illegal = (dec.id == INSTR_INVALID) || is_mem;

    assign wen = !illegal && (dec.rd != 5'd0)
              && !(dec.id inside {INSTR_BEQ, INSTR_BNE, INSTR_BLT, INSTR_BGE,
                                  INSTR_BLTU, INSTR_BGEU});

    assign wdata = wen ? result : '0;  // nothing shown when not writing

    always_comb begin
        if (dec.id == INSTR_JALR)
            next_pc = (rs1_data + dec.imm) & ~32'd1;
        else if (taken)
            next_pc = pc + dec.imm;
        else
            next_pc = pc_plus4;
    end

endmodule

/* source/rv_core.sv */
module rv_core import rv_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    instr_valid,
    input  xlen_t   instr,
    output xlen_t   fetch_pc,
    output logic    retire_valid,
    output retire_t retire
);

    xlen_t    pc;
    decoded_t dec;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    xlen_t    alu_wdata;
    logic     alu_wen;
    xlen_t    alu_next_pc;
    logic     alu_illegal;

    rv_decoder decoder_i (
        .instr (instr),
        .dec   (dec)
    );

    rv_regfile regfile_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .wen    (alu_wen && instr_valid),  // only on a real strobe
        .waddr  (dec.rd),
        .wdata  (alu_wdata),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    rv_alu alu_i (
        .dec      (dec),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wdata    (alu_wdata),
        .wen      (alu_wen),
        .next_pc  (alu_next_pc),
        .illegal  (alu_illegal)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (instr_valid) begin
            pc <= alu_next_pc;
        end
    end

    assign fetch_pc = pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= instr_valid;  // high for one cycle per strobe
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            retire.pc      <= pc;
            retire.instr   <= instr;
            retire.rd      <= dec.rd;
            retire.wdata   <= alu_wdata;
            retire.wen     <= alu_wen;
            retire.next_pc <= alu_next_pc;
            retire.illegal <= alu_illegal;
        end
    end

endmodule

/* tests/tb_clock.sv */
module tb_clock (
    output logic clk
);

    localparam int HALF_PERIOD = 4;  // 8 time unit period

    initial clk = 1'b0;

    always #HALF_PERIOD clk = ~clk;

endmodule

/* tests/rv_core_sva.sv */
module rv_core_sva import rv_pkg::*; (
    input logic    clk,
    input logic    rst_n,
    input logic    instr_valid,
    input xlen_t   fetch_pc,
    input logic    retire_valid,
    input retire_t retire
);

    // one retire per strobe, exactly one cycle later
    retire_follows_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid |=> retire_valid)
        else $error("retire_valid missing one cycle after instr_valid");

    no_retire_without_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        !instr_valid |=> !retire_valid)
        else $error("retire_valid high without instr_valid in the cycle before");

    x0_wdata_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (retire_valid && retire.rd == 5'd0) |-> retire.wdata == '0)
        else $error("nonzero wdata retired for rd x0");

    x0_never_written: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> !(retire.wen && retire.rd == 5'd0))
        else $error("wen retired with rd x0");

    pc_holds_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !instr_valid |=> fetch_pc == $past(fetch_pc))
        else $error("fetch_pc moved without instr_valid");

endmodule

/* tests/rv_core_tb.sv */
module rv_core_tb import rv_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_DIRECTED = 15;
    localparam int NUM_RANDOM   = 600;
    localparam int TIMEOUT      = (RESET_CYCLES + 20 * (NUM_DIRECTED + NUM_RANDOM)) * CLK_PERIOD;

    logic    clk;
    logic    rst_n;
    logic    instr_valid;
    xlen_t   instr;
    xlen_t   fetch_pc;
    logic    retire_valid;
    retire_t retire;

    logic [31:0] rand_state = 32'h81a3;
    xlen_t       model_regs [32];
    xlen_t       model_pc;
    xlen_t       last_next_pc;
    retire_t     exp_q [$];
    int          sent_count;
    int          retired_count;

    tb_clock clock_i (.clk(clk));

    rv_core dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .fetch_pc     (fetch_pc),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    bind rv_core rv_core_sva sva_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .fetch_pc     (fetch_pc),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    function automatic logic [31:0] lcg_next();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic xlen_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3,
                                     input reg_idx_t rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic xlen_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                     input logic [2:0] f3, input reg_idx_t rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic xlen_t s_type(input logic [11:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic xlen_t b_type(input logic [12:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic xlen_t u_type(input logic [19:0] imm, input reg_idx_t rd,
                                     input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic xlen_t j_type(input logic [20:0] imm, input reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // x1..x7 most of the time so results feed each other
    function automatic reg_idx_t pick_reg();
        logic [31:0] r;
        r = lcg_next();
        if (r[31:29] == 3'd0)
            return r[20:16];
        else if (r[18:16] == 3'd0)
            return 5'd1;
        else
            return {2'b00, r[18:16]};
    endfunction

    function automatic xlen_t gen_instr();
        logic [31:0] r;
        logic [31:0] v;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        xlen_t       ins;
        r   = lcg_next();
        v   = lcg_next();
        rd  = pick_reg();
        rs1 = pick_reg();
        rs2 = pick_reg();
        f3  = v[18:16];
        f7  = (v[20] && (f3 == 3'h0 || f3 == 3'h5)) ? F7_ALT : F7_BASE;
        if (v[27:24] == 4'd0)
            f7 = v[31:25];  // rare malformed funct7
        imm = v[31:20];
        case (r[19:16])
            4'd0, 4'd1, 4'd2, 4'd3: ins = r_type(f7, rs2, rs1, f3, rd, OPC_OP);
            4'd4, 4'd5, 4'd6: begin
                if (f3 == 3'h1 || f3 == 3'h5)
                    imm = {f7, v[24:20]};
                ins = i_type(imm, rs1, f3, rd, OPC_OP_IMM);
            end
            4'd7:    ins = u_type(v[31:12], rd, v[20] ? OPC_LUI : OPC_AUIPC);
            4'd8:    ins = j_type({v[31:12], 1'b0}, rd);
            4'd9:    ins = i_type(imm, rs1, (v[27:24] == 4'd1) ? f3 : 3'h0, rd, OPC_JALR);
            4'd10, 4'd11, 4'd12: ins = b_type({imm, 1'b0}, rs2, rs1, f3);
            4'd13:   ins = i_type(imm, rs1, f3, rd, OPC_LOAD);
            4'd14:   ins = s_type(imm, rs2, rs1, f3);
            default: ins = v;  // raw word, mostly unknown opcodes
        endcase
        return ins;
    endfunction

    function automatic xlen_t arith(input logic [2:0] f3, input logic alt,
                                    input xlen_t a, input xlen_t b);
        case (f3)
            3'h0:    return alt ? a - b : a + b;
            3'h1:    return a << b[4:0];
            3'h2:    return {31'd0, $signed(a) < $signed(b)};
            3'h3:    return {31'd0, a < b};
            3'h4:    return a ^ b;
            3'h5:    return alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'h6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // expected retire record from the architectural model
    function automatic retire_t predict(input xlen_t ins, input xlen_t pc);
        retire_t    exp;
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        xlen_t      a;
        xlen_t      b;
        xlen_t      imm_i;
        xlen_t      imm_b;
        xlen_t      imm_u;
        xlen_t      imm_j;
        xlen_t      val;
        xlen_t      npc;
        logic       legal;
        logic       writes;
        logic       taken;
        logic       has_rd;
        opc    = ins[6:0];
        f3     = ins[14:12];
        f7     = ins[31:25];
        a      = model_regs[ins[19:15]];
        b      = model_regs[ins[24:20]];
        imm_i  = {{20{ins[31]}}, ins[31:20]};
        imm_b  = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u  = {ins[31:12], 12'h000};
        imm_j  = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        legal  = 1'b1;
        writes = 1'b1;
        taken  = 1'b0;
        val    = '0;
        npc    = pc + 32'd4;
        has_rd = opc inside {OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_JALR, OPC_LUI, OPC_AUIPC,
                             OPC_JAL};
        case (opc)
            OPC_OP: begin
                legal = (f7 == F7_BASE) || (f7 == F7_ALT && (f3 == 3'h0 || f3 == 3'h5));
                val   = arith(f3, f7[5], a, b);
            end
            OPC_OP_IMM: begin
                if (f3 == 3'h1)
                    legal = (f7 == F7_BASE);
                if (f3 == 3'h5)
                    legal = (f7 == F7_BASE) || (f7 == F7_ALT);
                val = arith(f3, (f3 == 3'h5) && f7[5], a, imm_i);  // no subtract immediate
            end
            OPC_BRANCH: begin
                writes = 1'b0;
                case (f3)
                    3'h0:    taken = (a == b);
                    3'h1:    taken = (a != b);
                    3'h4:    taken = ($signed(a) < $signed(b));
                    3'h5:    taken = ($signed(a) >= $signed(b));
                    3'h6:    taken = (a < b);
                    3'h7:    taken = (a >= b);
                    default: legal = 1'b0;
                endcase
                if (taken)
                    npc = pc + imm_b;
            end
            OPC_JAL: begin
                val = pc + 32'd4;
                npc = pc + imm_j;
            end
            OPC_JALR: begin
                legal = (f3 == 3'h0);
                val   = pc + 32'd4;
                npc   = (a + imm_i) & 32'hffff_fffe;
            end
            OPC_LUI:   val = imm_u;
            OPC_AUIPC: val = pc + imm_u;
            default:   legal = 1'b0;  // loads, stores, unknown opcodes
        endcase
        exp.pc      = pc;
        exp.instr   = ins;
        exp.rd      = has_rd ? ins[11:7] : 5'd0;
        exp.wen     = legal && writes && (exp.rd != 5'd0);
        exp.wdata   = exp.wen ? val : '0;
        exp.next_pc = legal ? npc : pc + 32'd4;
        exp.illegal = !legal;
        return exp;
    endfunction

    task automatic stop_failed();
        $display("TB FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check(input string name, input xlen_t expected, input xlen_t actual);
        if (actual !== expected) begin
            $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            stop_failed();
        end
    endtask

    task automatic send(input xlen_t ins);
        retire_t exp;
        @(posedge clk);
        exp = predict(ins, model_pc);
        exp_q.push_back(exp);
        if (exp.wen)
            model_regs[exp.rd] = exp.wdata;
        model_pc = exp.next_pc;
        instr_valid <= 1'b1;
        instr       <= ins;
        sent_count++;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        instr_valid <= 1'b0;
        instr       <= lcg_next();  // garbage on the bus must be ignored
    endtask

    initial begin : stimulus
        logic [31:0] r;
        rst_n       <= 1'b0;
        instr_valid <= 1'b0;
        instr       <= '0;
        model_pc      = '0;
        last_next_pc  = '0;
        sent_count    = 0;
        retired_count = 0;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        send(r_type(F7_BASE, 5'd31, 5'd20, 3'h6, 5'd1, OPC_OP));  // reads reset regs
        send(i_type(12'h7ff, 5'd0, 3'h0, 5'd0, OPC_OP_IMM));      // write to x0
        send(r_type(F7_BASE, 5'd0, 5'd0, 3'h0, 5'd2, OPC_OP));
        send(i_type(12'h123, 5'd0, 3'h0, 5'd3, OPC_OP_IMM));
        send(i_type(12'h000, 5'd3, 3'h0, 5'd4, OPC_JALR));        // odd target
        send(u_type(20'h80000, 5'd5, OPC_LUI));
        send(u_type(20'h00001, 5'd6, OPC_AUIPC));
        send(j_type(21'h000010, 5'd7));
        send(b_type(13'h1ff8, 5'd5, 5'd5, 3'h0));                 // beq taken backwards
        send(i_type({F7_ALT, 5'd3}, 5'd5, 3'h1, 5'd1, OPC_OP_IMM));
        send(i_type({7'h10, 5'd3}, 5'd5, 3'h5, 5'd1, OPC_OP_IMM));
        send(r_type(7'h01, 5'd5, 5'd3, 3'h0, 5'd1, OPC_OP));
        send(i_type(12'h004, 5'd3, 3'h2, 5'd2, OPC_LOAD));
        send(s_type(12'h008, 5'd5, 5'd3, 3'h2));
        send(i_type({F7_ALT, 5'd4}, 5'd5, 3'h5, 5'd1, OPC_OP_IMM));

        for (int n = 0; n < NUM_RANDOM; n++) begin
            r = lcg_next();
            if (r[31:30] == 2'd0)
                repeat (int'(r[17:16]) + 1) idle_cycle();
            send(gen_instr());
        end
        idle_cycle();

        repeat (2) @(posedge clk);  // last retire is one cycle behind its strobe
        if (retired_count == sent_count && exp_q.size() == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("retired %0d instructions but sent %0d", retired_count, sent_count);
            stop_failed();
        end
    end

    // outputs settle well before the falling edge
    always @(negedge clk) begin : compare
        retire_t exp;
        if (rst_n) begin
            if (retire_valid) begin
                if (exp_q.size() == 0) begin
                    $display("retire reported at %0t with no instruction outstanding", $time);
                    stop_failed();
                end else begin
                    exp = exp_q.pop_front();
                    check("retire.pc", exp.pc, retire.pc);
                    check("retire.instr", exp.instr, retire.instr);
                    check("retire.rd", {27'd0, exp.rd}, {27'd0, retire.rd});
                    check("retire.wdata", exp.wdata, retire.wdata);
                    check("retire.wen", {31'd0, exp.wen}, {31'd0, retire.wen});
                    check("retire.next_pc", exp.next_pc, retire.next_pc);
                    check("retire.illegal", {31'd0, exp.illegal}, {31'd0, retire.illegal});
                    last_next_pc = exp.next_pc;
                    retired_count++;
                end
            end
            check("fetch_pc", last_next_pc, fetch_pc);
        end
    end

    initial begin : watchdog
        #(TIMEOUT);
        $display("watchdog expired at %0t, the run did not finish", $time);
        stop_failed();
    end

endmodule

/* compile.f */
common/rv_pkg.sv
decode/rv_decoder.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_core.sv
tests/tb_clock.sv
tests/rv_core_sva.sv
tests/rv_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rv_core_tb
MDIR      ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)
	@out=$$(./$(MDIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf $(MDIR)
